/* src/ec_time_to_sys_time.sv */
`timescale 1ns/1ns

module ec_time_to_sys_time (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  time_conv_pkg::ec_time_t  in_time,
  input  time_conv_pkg::conv_cfg_t cfg,
  output logic                     out_valid,
  input  logic                     out_ready,
  output time_conv_pkg::sys_time_t out_time,
  output logic                     done
);

  time_conv_pkg::conv_state_t state;
  time_conv_pkg::ec_time_t    time_q;
  time_conv_pkg::conv_cfg_t   cfg_q;
  logic                       div_start;

  logic                       quo_valid;
  time_conv_pkg::lap_t        quotient;
  logic                       scl_valid;
  time_conv_pkg::sys_time_t   scl_time;

  assign in_ready  = (state == time_conv_pkg::IDLE);
  assign out_valid = (state == time_conv_pkg::HOLD);
  assign done      = out_valid && out_ready;

  lap_divider u_divider (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .start     (div_start),
    .dividend  (time_q),
    .divisor   (cfg_q.divisor),
    .quo_valid (quo_valid),
    .quotient  (quotient)
  );

  // The quotient goes straight into the scaler on the cycle it becomes valid
  lap_scaler u_scaler (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .in_valid  (quo_valid),
    .lap       (quotient),
    .scale     (cfg_q.scale),
    .out_valid (scl_valid),
    .sys_time  (scl_time)
  );

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state     <= time_conv_pkg::IDLE;
      div_start <= 1'b0;
    end else begin
      div_start <= 1'b0;
      case (state)
        time_conv_pkg::IDLE: begin
          if (in_valid) begin
            state     <= time_conv_pkg::DIVIDE;
            div_start <= 1'b1;
          end
        end
        time_conv_pkg::DIVIDE: begin
          if (quo_valid) begin
            state <= time_conv_pkg::SCALE;
          end
        end
        time_conv_pkg::SCALE: begin
          if (scl_valid) begin
            state <= time_conv_pkg::HOLD;
          end
        end
        time_conv_pkg::HOLD: begin
          if (out_ready) begin
            state <= time_conv_pkg::IDLE;
          end
        end
        default: state <= time_conv_pkg::IDLE;
      endcase
    end
  end

  // Time and configuration are captured together, so later register writes
  // only reach the next conversion
  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      time_q <= in_time;
      cfg_q  <= cfg;
    end
    if (state == time_conv_pkg::SCALE && scl_valid) begin
      out_time <= scl_time;
    end
  end

endmodule

/* src/lap_divider.sv */
`timescale 1ns/1ns
`include "time_conv_config.svh"

module lap_divider (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  start,
  input  time_conv_pkg::ec_time_t dividend,
  input  time_conv_pkg::divisor_t divisor,
  output logic                  quo_valid,
  output time_conv_pkg::lap_t   quotient
);

  localparam int cnt_w = $clog2(`TC_LAP_W);

  logic                    busy;
  logic [cnt_w-1:0]        bit_cnt;
  time_conv_pkg::divisor_t rem_q;

  time_conv_pkg::divisor_t rem_in;
  time_conv_pkg::lap_t     quo_in;
  logic [`TC_DIVISOR_W:0]  trial;
  logic                    fits;
  time_conv_pkg::divisor_t rem_next;
  time_conv_pkg::lap_t     quo_next;

  // One restoring step per cycle
  // The dividend shifts out of the top of the quotient register as quotient bits shift in
  always_comb begin
    if (start) begin
      rem_in = '0;
      quo_in = dividend;
    end else begin
      rem_in = rem_q;
      quo_in = quotient;
    end
    trial = {rem_in, quo_in[`TC_LAP_W-1]};
    fits  = (trial >= {1'b0, divisor});
    if (fits) begin
      rem_next = time_conv_pkg::divisor_t'(trial - {1'b0, divisor});
    end else begin
      rem_next = trial[`TC_DIVISOR_W-1:0];
    end
    quo_next = {quo_in[`TC_LAP_W-2:0], fits};
  end

  // The first step runs on the start edge, so the last one lands 64 cycles after start
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      bit_cnt   <= '0;
      quo_valid <= 1'b0;
    end else begin
      quo_valid <= 1'b0;
      if (start) begin
        busy    <= 1'b1;
        bit_cnt <= cnt_w'(1);
      end else if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == cnt_w'(`TC_LAP_W - 1)) begin
          busy      <= 1'b0;
          quo_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start || busy) begin
      rem_q    <= rem_next;
      quotient <= quo_next;
    end
  end

endmodule

/* src/lap_scaler.sv */
`timescale 1ns/1ns
`include "time_conv_config.svh"

module lap_scaler (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic                     in_valid,
  input  time_conv_pkg::lap_t      lap,
  input  time_conv_pkg::scale_t    scale,
  output logic                     out_valid,
  output time_conv_pkg::sys_time_t sys_time
);

  localparam int half_w = `TC_SCALE_W / 2;
  localparam int prod_w = `TC_LAP_W + half_w;
  localparam int hi_w   = `TC_SYS_TIME_W - half_w;

  logic [prod_w-1:0]        pp_lo_d;
  logic [prod_w-1:0]        pp_hi_d;
  time_conv_pkg::sys_time_t pp_lo_q;
  logic [hi_w-1:0]          pp_hi_q;
  logic                     stage1_valid;

  // Bits above 61 never reach the result, so each partial product is trimmed early
  assign pp_lo_d = lap * scale[half_w-1:0];
  assign pp_hi_d = lap * scale[`TC_SCALE_W-1:half_w];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      stage1_valid <= 1'b0;
      out_valid    <= 1'b0;
    end else begin
      stage1_valid <= in_valid;
      out_valid    <= stage1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    pp_lo_q  <= pp_lo_d[`TC_SYS_TIME_W-1:0];
    pp_hi_q  <= pp_hi_d[hi_w-1:0];
    sys_time <= pp_lo_q + {pp_hi_q, {half_w{1'b0}}};
  end

endmodule

/* src/time_conv_config.svh */
`ifndef TIME_CONV_CONFIG_SVH
`define TIME_CONV_CONFIG_SVH

// Datapath widths
`define TC_EC_TIME_W   64
`define TC_LAP_W       64
`define TC_DIVISOR_W   16
`define TC_SCALE_W     12
`define TC_SYS_TIME_W  61

// Register port widths
`define TC_REG_ADDR_W  2
`define TC_REG_DATA_W  32
`define TC_COUNT_W     32

// Reset defaults give one lap per 15.625 us and 320 system ticks per lap
`define TC_DIVISOR_RST 16'd15625
`define TC_SCALE_RST   12'd320

`define TC_ADDR_DIVISOR 2'd0
`define TC_ADDR_SCALE   2'd1
`define TC_ADDR_COUNT   2'd2

`endif

/* src/time_conv_pkg.sv */
`include "time_conv_config.svh"

package time_conv_pkg;

  typedef logic [`TC_EC_TIME_W-1:0]  ec_time_t;
  typedef logic [`TC_LAP_W-1:0]      lap_t;
  typedef logic [`TC_DIVISOR_W-1:0]  divisor_t;
  typedef logic [`TC_SCALE_W-1:0]    scale_t;
  typedef logic [`TC_SYS_TIME_W-1:0] sys_time_t;

  typedef logic [`TC_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`TC_REG_DATA_W-1:0] reg_data_t;
  typedef logic [`TC_COUNT_W-1:0]    conv_count_t;

  // Configuration handed to the converter
  typedef struct packed {
    divisor_t divisor;
    scale_t   scale;
  } conv_cfg_t;

  // One register write
  typedef struct packed {
    reg_addr_t addr;
    reg_data_t data;
  } reg_wr_t;

  // Converter sequencing
  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    SCALE,
    HOLD
  } conv_state_t;

endpackage

/* src/time_conv_regs.sv */
`timescale 1ns/1ns
`include "time_conv_config.svh"

module time_conv_regs (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic                     reg_wr_en,
  input  time_conv_pkg::reg_wr_t   reg_wr,
  input  time_conv_pkg::reg_addr_t reg_rd_addr,
  output time_conv_pkg::reg_data_t reg_rd_data,
  input  logic                     done,
  output time_conv_pkg::conv_cfg_t cfg
);

  time_conv_pkg::divisor_t    divisor_q;
  time_conv_pkg::scale_t      scale_q;
  time_conv_pkg::conv_count_t count_q;

  assign cfg = '{divisor: divisor_q, scale: scale_q};

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      divisor_q <= `TC_DIVISOR_RST;
      scale_q   <= `TC_SCALE_RST;
    end else if (reg_wr_en) begin
      case (reg_wr.addr)
        `TC_ADDR_DIVISOR: begin
          // A zero lap period would stall every conversion, so it is dropped
          if (reg_wr.data[`TC_DIVISOR_W-1:0] != '0) begin
            divisor_q <= reg_wr.data[`TC_DIVISOR_W-1:0];
          end
        end
        `TC_ADDR_SCALE: begin
          scale_q <= reg_wr.data[`TC_SCALE_W-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // Free-running count of delivered results, wraps at 2^32
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else if (done) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    reg_rd_data = '0;
    case (reg_rd_addr)
      `TC_ADDR_DIVISOR: reg_rd_data = time_conv_pkg::reg_data_t'(divisor_q);
      `TC_ADDR_SCALE:   reg_rd_data = time_conv_pkg::reg_data_t'(scale_q);
      `TC_ADDR_COUNT:   reg_rd_data = time_conv_pkg::reg_data_t'(count_q);
      default:          reg_rd_data = '0;
    endcase
  end

endmodule

/* src/time_conv_top.sv */
`timescale 1ns/1ns

module time_conv_top (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  time_conv_pkg::ec_time_t  in_time,
  output logic                     out_valid,
  input  logic                     out_ready,
  output time_conv_pkg::sys_time_t out_time,
  input  logic                     reg_wr_en,
  input  time_conv_pkg::reg_wr_t   reg_wr,
  input  time_conv_pkg::reg_addr_t reg_rd_addr,
  output time_conv_pkg::reg_data_t reg_rd_data
);

  time_conv_pkg::conv_cfg_t cfg;
  logic                     done;

  time_conv_regs u_regs (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .reg_wr_en   (reg_wr_en),
    .reg_wr      (reg_wr),
    .reg_rd_addr (reg_rd_addr),
    .reg_rd_data (reg_rd_data),
    .done        (done),
    .cfg         (cfg)
  );

  ec_time_to_sys_time conv (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_time   (in_time),
    .cfg       (cfg),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_time  (out_time),
    .done      (done)
  );

endmodule

/* tb/time_conv_chk.sv */
`timescale 1ns/1ns

module time_conv_chk (
  input logic                       CLK,
  input logic                       arst_n,
  input logic                       in_ready,
  input logic                       out_valid,
  input logic                       out_ready,
  input time_conv_pkg::sys_time_t   out_time,
  input logic                       done,
  input logic                       div_start,
  input logic                       quo_valid,
  input time_conv_pkg::conv_state_t state
);

  int   assert_fails = 0;
  logic div_busy;

  // Follows the divider from its start pulse to its quotient
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      div_busy <= 1'b0;
    end else if (div_start) begin
      div_busy <= 1'b1;
    end else if (quo_valid) begin
      div_busy <= 1'b0;
    end
  end

  // A stalled result must not move until it is taken
  a_hold_stable: assert property (@(posedge CLK) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_time))
    else begin
      $error("out_valid or out_time changed while out_ready was low");
      assert_fails++;
    end

  // Once a conversion is under way the input stays closed until its result is taken
  a_ready_idle: assert property (@(posedge CLK) disable iff (!arst_n)
    state != time_conv_pkg::IDLE && !done |=> !in_ready)
    else begin
      $error("in_ready rose before the pending result was transferred");
      assert_fails++;
    end

  // The transfer ends the conversion, so done is a single pulse and the input reopens
  a_done_xfer: assert property (@(posedge CLK) disable iff (!arst_n)
    done |=> !done && !out_valid && in_ready)
    else begin
      $error("done was not followed by a return to IDLE");
      assert_fails++;
    end

  a_no_restart: assert property (@(posedge CLK) disable iff (!arst_n)
    div_start |-> !div_busy)
    else begin
      $error("divider started while a division was still running");
      assert_fails++;
    end

  a_reset_quiet: assert property (@(posedge CLK)
    !arst_n |-> in_ready && !out_valid && !done && !div_start)
    else begin
      $error("control outputs are active during reset");
      assert_fails++;
    end

endmodule

bind ec_time_to_sys_time time_conv_chk u_chk (
  .CLK       (CLK),
  .arst_n    (arst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_time  (out_time),
  .done      (done),
  .div_start (div_start),
  .quo_valid (quo_valid),
  .state     (state)
);

/* tb/time_conv_stimulus.txt */
# op name op_a op_b expected, all numbers in hex
# op_a is the address or the input time, op_b the write data or a scale written mid-conversion
R rst_divisor 0 0 3d09
R rst_scale 1 0 140
R rst_count 2 0 0
C zero 0 0 0
C below_lap 3d08 0 0
C at_lap 3d09 0 140
C above_lap2 7a13 0 280
C max_default ffffffffffffffff 0 53e2d6238da3bc0
W set_divisor 0 3e8 3e8
W set_scale 1 7 7
C new_cfg 75bcd15 0 d2fc0
W zero_divisor 0 0 3e8
C kept_divisor f4240 0 1b58
W div_one 0 1 1
W scale_max 1 fff fff
C max_trunc ffffffffffffffff 0 1ffffffffffff001
W div_default 0 3d09 3d09
C inflight_wr 7a13 a 1ffe
C after_wr 7a13 0 14
R scale_rb 1 0 a
R conv_count 2 0 a

/* tb/time_conv_tb.sv */
`timescale 1ns/1ns
`include "time_conv_config.svh"

module time_conv_tb;

  localparam int MAX_STALL = 8;
  localparam int NAME_W    = 8 * 24;

  logic                     CLK;
  logic                     arst_n;
  logic                     in_valid;
  logic                     in_ready;
  time_conv_pkg::ec_time_t  in_time;
  logic                     out_valid;
  logic                     out_ready;
  time_conv_pkg::sys_time_t out_time;
  logic                     reg_wr_en;
  time_conv_pkg::reg_wr_t   reg_wr;
  time_conv_pkg::reg_addr_t reg_rd_addr;
  time_conv_pkg::reg_data_t reg_rd_data;

  integer seed;
  int     errors;
  int     tests;
  int     failed_tests;
  int     cycles;
  int     limit;

  // Configuration as the testbench expects the registers to hold it
  time_conv_pkg::divisor_t div_model;
  time_conv_pkg::scale_t   scale_model;

  logic [7:0]        op_q[$];
  logic [NAME_W-1:0] name_q[$];
  logic [63:0]       a0_q[$];
  logic [63:0]       a1_q[$];
  logic [63:0]       exp_q[$];

  time_conv_top uut (.*);

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  task automatic check_sys_time(input logic [NAME_W-1:0] name,
                                input time_conv_pkg::sys_time_t exp,
                                input time_conv_pkg::sys_time_t act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg(input logic [NAME_W-1:0] name,
                           input time_conv_pkg::reg_data_t exp,
                           input time_conv_pkg::reg_data_t act);
    if (act !== exp) begin
      errors++;
      $display("ERR %0s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Whole laps times scale, kept to the low 61 bits
  function automatic time_conv_pkg::sys_time_t expected_sys_time(
      input time_conv_pkg::ec_time_t t, input time_conv_pkg::divisor_t d,
      input time_conv_pkg::scale_t s);
    time_conv_pkg::lap_t laps;
    logic [63:0]         prod;
    laps = t / d;
    prod = laps * 64'(s);
    return prod[`TC_SYS_TIME_W-1:0];
  endfunction

  task automatic apply_model_write(input time_conv_pkg::reg_addr_t addr,
                                   input time_conv_pkg::reg_data_t data);
    if (addr == `TC_ADDR_DIVISOR && data[`TC_DIVISOR_W-1:0] != '0) begin
      div_model = data[`TC_DIVISOR_W-1:0];
    end else if (addr == `TC_ADDR_SCALE) begin
      scale_model = data[`TC_SCALE_W-1:0];
    end
  endtask

  // Called 2 ns after a rising edge and returns at the same point one cycle later
  task automatic drive_write(input time_conv_pkg::reg_addr_t addr,
                             input time_conv_pkg::reg_data_t data);
    reg_wr_en   = 1'b1;
    reg_wr.addr = addr;
    reg_wr.data = data;
    @(posedge CLK);
    #2;
    reg_wr_en = 1'b0;
  endtask

  task automatic write_and_readback(input logic [NAME_W-1:0] name,
                                    input time_conv_pkg::reg_addr_t addr,
                                    input time_conv_pkg::reg_data_t data,
                                    input time_conv_pkg::reg_data_t exp);
    @(posedge CLK);
    #2;
    drive_write(addr, data);
    apply_model_write(addr, data);
    reg_rd_addr = addr;
    @(negedge CLK);
    check_reg(name, exp, reg_rd_data);
  endtask

  task automatic read_and_compare(input logic [NAME_W-1:0] name,
                                  input time_conv_pkg::reg_addr_t addr,
                                  input time_conv_pkg::reg_data_t exp);
    @(posedge CLK);
    #2;
    reg_rd_addr = addr;
    @(negedge CLK);
    check_reg(name, exp, reg_rd_data);
  endtask

  task automatic convert_and_check(input logic [NAME_W-1:0] name,
                                   input time_conv_pkg::ec_time_t t,
                                   input time_conv_pkg::reg_data_t wr_scale,
                                   input time_conv_pkg::sys_time_t exp);
    time_conv_pkg::sys_time_t model;
    time_conv_pkg::sys_time_t held;
    int                       stall;
    model = expected_sys_time(t, div_model, scale_model);
    stall = $unsigned($random(seed)) % (MAX_STALL + 1);
    @(posedge CLK);
    #2;
    in_valid = 1'b1;
    in_time  = t;
    @(negedge CLK);
    while (!in_ready) @(negedge CLK);
    @(posedge CLK);
    #2;
    in_valid = 1'b0;
    // This write lands while the divider is busy with the accepted input
    if (wr_scale != '0) begin
      drive_write(`TC_ADDR_SCALE, wr_scale);
      apply_model_write(`TC_ADDR_SCALE, wr_scale);
    end
    @(negedge CLK);
    while (!out_valid) @(negedge CLK);
    held = out_time;
    repeat (stall) begin
      @(negedge CLK);
      if (!out_valid || out_time !== held || in_ready) begin
        errors++;
        $display("%0s: result moved or input reopened while the output was stalled", name);
      end
    end
    @(posedge CLK);
    #2;
    out_ready = 1'b1;
    @(negedge CLK);
    check_sys_time(name, exp, out_time);
    check_sys_time(name, model, out_time);
    @(posedge CLK);
    #2;
    out_ready = 1'b0;
    @(negedge CLK);
    if (out_valid) begin
      errors++;
      $display("%0s: result was presented again after its transfer", name);
    end
  endtask

  task automatic load_stimulus();
    int                fd;
    int                n;
    logic [8*160-1:0]  line_v;
    logic [7:0]        op;
    logic [NAME_W-1:0] name;
    logic [63:0]       a0;
    logic [63:0]       a1;
    logic [63:0]       ex;
    fd = $fopen("tb/time_conv_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open tb/time_conv_stimulus.txt");
    end else begin
      line_v = '0;
      while ($fgets(line_v, fd) != 0) begin
        n = $sscanf(line_v, "%s %s %h %h %h", op, name, a0, a1, ex);
        if (n == 5 && op != "#") begin
          op_q.push_back(op);
          name_q.push_back(name);
          a0_q.push_back(a0);
          a1_q.push_back(a1);
          exp_q.push_back(ex);
        end
        line_v = '0;
      end
      $fclose(fd);
    end
  endtask

  initial begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge CLK);
      cycles++;
    end
    $display("timeout after %0d cycles, the DUT stopped responding", limit);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int err_before;
    int i;
    seed         = 51327;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    limit        = 0;
    arst_n       = 1'b1;
    in_valid     = 1'b0;
    in_time      = '0;
    out_ready    = 1'b0;
    reg_wr_en    = 1'b0;
    reg_wr       = '0;
    reg_rd_addr  = '0;
    div_model    = `TC_DIVISOR_RST;
    scale_model  = `TC_SCALE_RST;
    load_stimulus();
    limit = op_q.size() * (67 + MAX_STALL + 10);
    #2;
    arst_n = 1'b0;
    repeat (2) @(posedge CLK);
    #2;
    arst_n = 1'b1;
    for (i = 0; i < op_q.size(); i++) begin
      err_before = errors;
      case (op_q[i])
        "W": write_and_readback(name_q[i], time_conv_pkg::reg_addr_t'(a0_q[i]),
                                time_conv_pkg::reg_data_t'(a1_q[i]),
                                time_conv_pkg::reg_data_t'(exp_q[i]));
        "C": convert_and_check(name_q[i], a0_q[i], time_conv_pkg::reg_data_t'(a1_q[i]),
                               time_conv_pkg::sys_time_t'(exp_q[i]));
        "R": read_and_compare(name_q[i], time_conv_pkg::reg_addr_t'(a0_q[i]),
                              time_conv_pkg::reg_data_t'(exp_q[i]));
        default: begin
          errors++;
          $display("unknown opcode in test %0s", name_q[i]);
        end
      endcase
      tests++;
      if (errors != err_before) begin
        failed_tests++;
        $display("test %0s: failed", name_q[i]);
      end else begin
        $display("test %0s: ok", name_q[i]);
      end
    end
    if (uut.conv.u_chk.assert_fails != 0) begin
      errors += uut.conv.u_chk.assert_fails;
      $display("%0d assertion failures in the converter checker", uut.conv.u_chk.assert_fails);
    end
    $display("tests run %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+src
src/time_conv_pkg.sv
src/lap_divider.sv
src/lap_scaler.sv
src/ec_time_to_sys_time.sv
src/time_conv_regs.sv
src/time_conv_top.sv
tb/time_conv_chk.sv
tb/time_conv_tb.sv
